// ==== verilog/tomasulo_pkg.sv ====
package tomasulo_pkg;

    // operand and result widths
    localparam int DATA_W   = 8;
    localparam int RESULT_W = 16;

    // architectural index widths
    localparam int REG_W = 4;  // 16 registers
    localparam int ROB_W = 3;  // 8 rob entries

    // value broadcast for a divide by zero
    localparam logic [RESULT_W-1:0] DIV_ZERO_RESULT = 16'h00FF;

    // function codes seen by the mul/div cluster
    typedef enum logic [3:0] {
        FUNC_MUL = 4'd2,  // full 16-bit product
        FUNC_DIV = 4'd3   // 8-bit quotient, zero extended
    } func_e;

endpackage

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    import tomasulo_pkg::*;

    localparam int NUM_UNITS  = 2;
    localparam int UNIT_IDX_W = $clog2(NUM_UNITS);
    localparam int RS_DEPTH   = 3;
    localparam int RS_IDX_W   = 2;
    localparam int MUL_LAT    = 3;
    localparam int DIV_LAT    = 8;  // one quotient bit per cycle
    localparam int LAT_CNT_W  = $clog2(DIV_LAT);

    typedef struct packed {
        logic              ready;
        logic [ROB_W-1:0]  tag;    // producer rob index
        logic [DATA_W-1:0] value;
    } operand_t;

    typedef struct packed {
        func_e             func;
        logic [REG_W-1:0]  rd;
        logic [ROB_W-1:0]  rob_ind;
        operand_t          src1;
        operand_t          src2;
    } issue_op_t;

    typedef struct packed {
        func_e             func;
        logic [REG_W-1:0]  rd;
        logic [ROB_W-1:0]  rob_ind;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } exec_req_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_W-1:0]    rob_ind;
        logic [REG_W-1:0]    rd;
        logic [RESULT_W-1:0] value;
    } cdb_t;

    typedef enum logic [1:0] {
        UNIT_IDLE,
        UNIT_BUSY,
        UNIT_DONE
    } unit_state_e;

endpackage

// ==== verilog/mul_rs.sv ====
`timescale 1ns/1ps

module mul_rs
    import tomasulo_pkg::*;
    import exec_pkg::*;
(
    input  logic                 clk1,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  issue_op_t            issue_op,
    output logic                 issue_full,
    input  cdb_t                 cdb,
    input  cdb_t                 ext_cdb,
    input  logic [NUM_UNITS-1:0] unit_busy,
    output logic [NUM_UNITS-1:0] start,
    output exec_req_t            exec_req
);

    logic [RS_DEPTH-1:0]   ent_valid;
    issue_op_t             ent_op [RS_DEPTH];
    logic [RS_DEPTH-1:0]   ent_ready;
    logic [RS_IDX_W-1:0]   free_ent;
    logic [RS_IDX_W-1:0]   disp_ent;
    logic [UNIT_IDX_W-1:0] disp_unit;
    logic                  disp_go;
    logic                  issue_accept;
    issue_op_t             new_op;

    // capture a broadcast value if this operand waits on its tag
    function automatic operand_t wake(operand_t opnd, cdb_t bus_a, cdb_t bus_b);
        operand_t r;
        r = opnd;
        if (!opnd.ready && bus_a.valid && bus_a.rob_ind == opnd.tag)
        begin
            r.ready = 1'b1;
            r.value = bus_a.value[DATA_W-1:0];
        end
        else if (!opnd.ready && bus_b.valid && bus_b.rob_ind == opnd.tag)
        begin
            r.ready = 1'b1;
            r.value = bus_b.value[DATA_W-1:0];
        end
        return r;
    endfunction

    assign issue_full   = &ent_valid;
    assign issue_accept = issue_valid && !issue_full;

    // issued op may see its producer on the bus this same cycle
    always_comb
    begin
        new_op      = issue_op;
        new_op.src1 = wake(issue_op.src1, cdb, ext_cdb);
        new_op.src2 = wake(issue_op.src2, cdb, ext_cdb);
    end

    always_comb
    begin
        free_ent = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
        begin
            if (!ent_valid[i])
                free_ent = RS_IDX_W'(i);  // lowest free wins
        end
    end

    always_comb
    begin
        for (int i = 0; i < RS_DEPTH; i++)
            ent_ready[i] = ent_valid[i] && ent_op[i].src1.ready && ent_op[i].src2.ready;
    end

    // lowest ready entry to lowest free unit
    always_comb
    begin
        disp_ent  = '0;
        disp_unit = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
        begin
            if (ent_ready[i])
                disp_ent = RS_IDX_W'(i);
        end
        for (int u = NUM_UNITS - 1; u >= 0; u--)
        begin
            if (!unit_busy[u])
                disp_unit = UNIT_IDX_W'(u);
        end
        disp_go = |ent_ready && !(&unit_busy);
    end

    always_comb
    begin
        start = '0;
        if (disp_go)
            start[disp_unit] = 1'b1;
    end

    always_comb
    begin
        exec_req.func    = ent_op[disp_ent].func;
        exec_req.rd      = ent_op[disp_ent].rd;
        exec_req.rob_ind = ent_op[disp_ent].rob_ind;
        exec_req.a       = ent_op[disp_ent].src1.value;
        exec_req.b       = ent_op[disp_ent].src2.value;
    end

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            ent_valid <= '0;
        end
        else
        begin
            if (disp_go)
                ent_valid[disp_ent] <= 1'b0;
            if (issue_accept)
                ent_valid[free_ent] <= 1'b1;  // never the dispatching entry
        end
    end

    always_ff @(posedge clk1)
    begin
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            ent_op[i].src1 <= wake(ent_op[i].src1, cdb, ext_cdb);
            ent_op[i].src2 <= wake(ent_op[i].src2, cdb, ext_cdb);
        end
        if (issue_accept)
            ent_op[free_ent] <= new_op;
    end

    a_no_issue_when_full: assert property (
        @(posedge clk1) disable iff (rst) issue_valid |-> !issue_full);

    a_start_onehot: assert property (
        @(posedge clk1) disable iff (rst) $onehot0(start));

endmodule

// ==== verilog/mul_div_unit.sv ====
`timescale 1ns/1ps

module mul_div_unit
    import tomasulo_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk1,
    input  logic      rst,
    input  logic      start,
    input  exec_req_t req,
    output logic      busy,
    output logic      done,
    output cdb_t      result,
    input  logic      grant
);

    unit_state_e          state;
    logic [LAT_CNT_W-1:0] cnt;
    logic                 is_div;
    logic [DATA_W-1:0]    divisor;
    logic [DATA_W-1:0]    rem;
    logic [DATA_W-1:0]    quo;
    logic [DATA_W-1:0]    step_rem;
    logic [DATA_W-1:0]    step_quo;
    logic [DATA_W-1:0]    step_div;
    logic [DATA_W:0]      shifted;
    logic [DATA_W-1:0]    rem_nxt;
    logic [DATA_W-1:0]    quo_nxt;
    logic [ROB_W-1:0]     res_rob;
    logic [REG_W-1:0]     res_rd;
    logic [RESULT_W-1:0]  res_value;

    assign busy = (state != UNIT_IDLE);
    assign done = (state == UNIT_DONE);

    // first quotient bit is taken in the start cycle
    assign step_rem = (state == UNIT_IDLE) ? '0    : rem;
    assign step_quo = (state == UNIT_IDLE) ? req.a : quo;
    assign step_div = (state == UNIT_IDLE) ? req.b : divisor;

    // one restoring shift-subtract step
    always_comb
    begin
        shifted = {step_rem, step_quo[DATA_W-1]};
        if (shifted >= {1'b0, step_div})
        begin
            rem_nxt = DATA_W'(shifted - {1'b0, step_div});
            quo_nxt = {step_quo[DATA_W-2:0], 1'b1};
        end
        else
        begin
            rem_nxt = shifted[DATA_W-1:0];
            quo_nxt = {step_quo[DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            state <= UNIT_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                UNIT_IDLE:
                begin
                    if (start)
                    begin
                        state <= UNIT_BUSY;
                        cnt   <= (req.func == FUNC_MUL) ? LAT_CNT_W'(MUL_LAT - 1)
                                                        : LAT_CNT_W'(DIV_LAT - 1);
                    end
                end
                UNIT_BUSY:
                begin
                    cnt <= cnt - 1'b1;
                    if (cnt == LAT_CNT_W'(1))
                        state <= UNIT_DONE;
                end
                UNIT_DONE:
                begin
                    if (grant)
                        state <= UNIT_IDLE;  // result taken by the arbiter
                end
                default:
                    state <= UNIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk1)
    begin
        if (state == UNIT_IDLE && start)
        begin
            is_div    <= (req.func == FUNC_DIV);
            res_rob   <= req.rob_ind;
            res_rd    <= req.rd;
            divisor   <= req.b;
            rem       <= rem_nxt;
            quo       <= quo_nxt;
            res_value <= RESULT_W'(req.a) * RESULT_W'(req.b);
        end
        else if (state == UNIT_BUSY && is_div)
        begin
            rem <= rem_nxt;
            quo <= quo_nxt;
            if (cnt == LAT_CNT_W'(1))
                res_value <= (divisor == '0) ? DIV_ZERO_RESULT : RESULT_W'(quo_nxt);
        end
    end

    always_comb
    begin
        result.valid   = done;
        result.rob_ind = res_rob;
        result.rd      = res_rd;
        result.value   = res_value;
    end

    a_start_when_idle: assert property (
        @(posedge clk1) disable iff (rst) start |-> state == UNIT_IDLE);

    a_grant_when_done: assert property (
        @(posedge clk1) disable iff (rst) grant |-> done);

endmodule

// ==== verilog/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import exec_pkg::*;
(
    input  logic                 clk1,
    input  logic                 rst,
    input  logic [NUM_UNITS-1:0] done,
    input  cdb_t                 unit_result [NUM_UNITS],
    output logic [NUM_UNITS-1:0] grant,
    output cdb_t                 cdb
);

    logic [UNIT_IDX_W-1:0] ptr;  // first unit to look at
    logic [UNIT_IDX_W-1:0] sel;
    logic                  found;

    always_comb
    begin
        int idx;
        grant = '0;
        sel   = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_UNITS; k++)
        begin
            idx = int'(ptr) + k;
            if (idx >= NUM_UNITS)
                idx = idx - NUM_UNITS;
            if (!found && done[idx])
            begin
                found = 1'b1;
                sel   = UNIT_IDX_W'(idx);
            end
        end
        if (found)
            grant[sel] = 1'b1;
    end

    always_ff @(posedge clk1)
    begin
        if (rst)
            ptr <= '0;
        else if (found)
            ptr <= (sel == UNIT_IDX_W'(NUM_UNITS - 1)) ? '0 : sel + 1'b1;
    end

    // bus is one cycle behind the grant
    always_ff @(posedge clk1)
    begin
        if (rst)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= found;
        if (found)
        begin
            cdb.rob_ind <= unit_result[sel].rob_ind;
            cdb.rd      <= unit_result[sel].rd;
            cdb.value   <= unit_result[sel].value;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk1) disable iff (rst) $onehot0(grant));

endmodule

// ==== verilog/mul_cluster_top.sv ====
`timescale 1ns/1ps

module mul_cluster_top
    import exec_pkg::*;
(
    input  logic      clk1,
    input  logic      rst,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      issue_full,
    input  cdb_t      ext_cdb,
    output cdb_t      cdb
);

    logic [NUM_UNITS-1:0] unit_busy;
    logic [NUM_UNITS-1:0] unit_start;
    logic [NUM_UNITS-1:0] unit_done;
    logic [NUM_UNITS-1:0] unit_grant;
    exec_req_t            exec_req;  // shared by all units
    cdb_t                 unit_result [NUM_UNITS];

    mul_rs mul_rs_inst (
        .clk1        (clk1),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_full  (issue_full),
        .cdb         (cdb),
        .ext_cdb     (ext_cdb),
        .unit_busy   (unit_busy),
        .start       (unit_start),
        .exec_req    (exec_req)
    );

    for (genvar i = 0; i < NUM_UNITS; i++)
    begin : g_unit
        mul_div_unit unit_inst (
            .clk1   (clk1),
            .rst    (rst),
            .start  (unit_start[i]),
            .req    (exec_req),
            .busy   (unit_busy[i]),
            .done   (unit_done[i]),
            .result (unit_result[i]),
            .grant  (unit_grant[i])
        );
    end

    cdb_arbiter cdb_arbiter_inst (
        .clk1        (clk1),
        .rst         (rst),
        .done        (unit_done),
        .unit_result (unit_result),
        .grant       (unit_grant),
        .cdb         (cdb)
    );

endmodule

// ==== tb/tb_mul_cluster.sv ====
`timescale 1ns/1ps

module tb_mul_cluster
    import tomasulo_pkg::*;
    import exec_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int NUM_ROB = 1 << ROB_W;

    logic      clk1;
    logic      rst;
    logic      issue_valid;
    issue_op_t issue_op;
    logic      issue_full;
    cdb_t      ext_cdb;
    cdb_t      cdb;

    logic [15:0]         lfsr_state;
    int                  errors;
    int                  err_start;
    int                  tests_run;
    int                  tests_failed;
    int                  bcast_total;
    int                  seen_cnt [NUM_ROB];
    int                  seen_seq [NUM_ROB];
    int                  base_cnt [NUM_ROB];
    logic [REG_W-1:0]    seen_rd  [NUM_ROB];
    logic [RESULT_W-1:0] seen_val [NUM_ROB];
    logic                exp_used [NUM_ROB];
    logic [REG_W-1:0]    exp_rd   [NUM_ROB];
    logic [RESULT_W-1:0] exp_val  [NUM_ROB];

    mul_cluster_top mul_cluster_top_inst (
        .clk1        (clk1),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_full  (issue_full),
        .ext_cdb     (ext_cdb),
        .cdb         (cdb)
    );

    initial
    begin
        clk1 = 1'b0;
        forever #4 clk1 = ~clk1;
    end

    // bus value of the cycle that ends here
    always @(posedge clk1)
    begin
        if (!rst && cdb.valid)
        begin
            seen_cnt[cdb.rob_ind] = seen_cnt[cdb.rob_ind] + 1;
            seen_seq[cdb.rob_ind] = bcast_total;
            seen_rd[cdb.rob_ind]  = cdb.rd;
            seen_val[cdb.rob_ind] = cdb.value;
            bcast_total           = bcast_total + 1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
    endtask

    function automatic logic [RESULT_W-1:0] ref_result(input func_e f, input logic [7:0] a, b);
        if (f == FUNC_MUL)
            return {8'h00, a} * {8'h00, b};
        if (b == 8'h00)
            return 16'h00FF;
        return {8'h00, a / b};
    endfunction

    function automatic operand_t opnd(input logic rdy, input logic [ROB_W-1:0] tag,
                                      input logic [DATA_W-1:0] val);
        return '{ready: rdy, tag: tag, value: val};
    endfunction

    function automatic issue_op_t make_op(input func_e f, input logic [ROB_W-1:0] rob,
                                          input logic [REG_W-1:0] rd, input operand_t s1, s2);
        return '{func: f, rd: rd, rob_ind: rob, src1: s1, src2: s2};
    endfunction

    // called just after a falling edge
    task automatic issue(input issue_op_t op);
        int n;
        n = 0;
        while (issue_full && n < TIMEOUT)
        begin
            @(negedge clk1);
            n++;
        end
        if (issue_full)
        begin
            $display("station stayed full, issue of rob %0d dropped", op.rob_ind);
            errors++;
        end
        else
        begin
            issue_valid = 1'b1;
            issue_op    = op;
            @(negedge clk1);
            issue_valid = 1'b0;
        end
    endtask

    task automatic expect_result(input logic [ROB_W-1:0] rob, input logic [REG_W-1:0] rd,
                                 input logic [RESULT_W-1:0] value);
        exp_used[rob] = 1'b1;
        exp_rd[rob]   = rd;
        exp_val[rob]  = value;
    endtask

    task automatic issue_ready(input func_e f, input logic [ROB_W-1:0] rob,
                               input logic [REG_W-1:0] rd, input logic [7:0] a, b);
        expect_result(rob, rd, ref_result(f, a, b));
        issue(make_op(f, rob, rd, opnd(1'b1, 3'd0, a), opnd(1'b1, 3'd0, b)));
    endtask

    task automatic wait_bcast(input int rob);
        int n;
        n = 0;
        while (seen_cnt[rob] == base_cnt[rob] && n < TIMEOUT)
        begin
            @(negedge clk1);
            n++;
        end
        if (seen_cnt[rob] == base_cnt[rob])
        begin
            $display("no broadcast for rob %0d within %0d cycles", rob, TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_all();
        int cnt;
        for (int i = 0; i < NUM_ROB; i++)
        begin
            if (exp_used[i])
                wait_bcast(i);
        end
        for (int i = 0; i < NUM_ROB; i++)
        begin
            cnt = seen_cnt[i] - base_cnt[i];
            if (exp_used[i] && cnt > 1)
            begin
                $display("rob %0d broadcast %0d times instead of once", i, cnt);
                errors++;
            end
            else if (exp_used[i] && cnt == 1)
            begin
                if (seen_rd[i] !== exp_rd[i])
                begin
                    $display("** Error cdb.rd rob %0d: expected %h, got %h",
                             i, exp_rd[i], seen_rd[i]);
                    errors++;
                end
                if (seen_val[i] !== exp_val[i])
                begin
                    $display("** Error cdb.value rob %0d: expected %h, got %h",
                             i, exp_val[i], seen_val[i]);
                    errors++;
                end
            end
            else if (!exp_used[i] && cnt != 0)
            begin
                $display("unexpected broadcast for rob %0d", i);
                errors++;
            end
            exp_used[i] = 1'b0;
        end
    endtask

    task automatic start_test();
        err_start = errors;
        for (int i = 0; i < NUM_ROB; i++)
            base_cnt[i] = seen_cnt[i];
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_start)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_reset();
        int start_total;
        start_test();
        start_total = bcast_total;
        if (cdb.valid !== 1'b0)
        begin
            $display("** Error cdb.valid: expected 0, got %h", cdb.valid);
            errors++;
        end
        if (issue_full !== 1'b0)
        begin
            $display("** Error issue_full: expected 0, got %h", issue_full);
            errors++;
        end
        repeat (20) @(negedge clk1);
        if (bcast_total != start_total)
        begin
            $display("broadcast seen with nothing issued");
            errors++;
        end
        finish_test("reset");
    endtask

    task automatic test_multiply();
        start_test();
        issue_ready(FUNC_MUL, 3'd0, 4'd1, 8'd3, 8'd5);
        issue_ready(FUNC_MUL, 3'd1, 4'd2, 8'd255, 8'd255);
        issue_ready(FUNC_MUL, 3'd2, 4'd3, 8'd0, 8'd77);
        issue_ready(FUNC_MUL, 3'd3, 4'd15, 8'd16, 8'd16);
        check_all();
        finish_test("multiply");
    endtask

    task automatic test_divide();
        start_test();
        issue_ready(FUNC_DIV, 3'd0, 4'd4, 8'd200, 8'd7);
        issue_ready(FUNC_DIV, 3'd1, 4'd5, 8'd255, 8'd1);
        issue_ready(FUNC_DIV, 3'd2, 4'd6, 8'd9, 8'd0);  // zero divisor
        issue_ready(FUNC_DIV, 3'd3, 4'd7, 8'd5, 8'd9);
        issue_ready(FUNC_DIV, 3'd4, 4'd8, 8'd0, 8'd0);
        check_all();
        finish_test("divide");
    endtask

    task automatic test_ext_wakeup();
        int start_total;
        start_test();
        expect_result(3'd3, 4'd7, ref_result(FUNC_MUL, 8'h34, 8'd9));
        issue(make_op(FUNC_MUL, 3'd3, 4'd7, opnd(1'b0, 3'd5, 8'h00), opnd(1'b1, 3'd0, 8'd9)));
        start_total = bcast_total;
        repeat (DIV_LAT + 12) @(negedge clk1);
        if (bcast_total != start_total)
        begin
            $display("broadcast before the external wakeup");
            errors++;
        end
        // producer on ext_cdb in the same cycle as this issue
        expect_result(3'd4, 4'd8, ref_result(FUNC_DIV, 8'd200, 8'h34));
        ext_cdb = '{valid: 1'b1, rob_ind: 3'd5, rd: 4'd0, value: 16'h1234};
        issue(make_op(FUNC_DIV, 3'd4, 4'd8, opnd(1'b1, 3'd0, 8'd200), opnd(1'b0, 3'd5, 8'h00)));
        ext_cdb = '0;
        check_all();
        finish_test("external wakeup");
    endtask

    task automatic test_chain();
        logic [RESULT_W-1:0] prod;
        start_test();
        prod = ref_result(FUNC_DIV, 8'd200, 8'd7);
        issue_ready(FUNC_DIV, 3'd1, 4'd9, 8'd200, 8'd7);
        expect_result(3'd2, 4'd10, ref_result(FUNC_MUL, prod[7:0], 8'd5));
        issue(make_op(FUNC_MUL, 3'd2, 4'd10, opnd(1'b0, 3'd1, 8'h00), opnd(1'b1, 3'd0, 8'd5)));
        check_all();
        if (seen_cnt[1] > base_cnt[1] && seen_cnt[2] > base_cnt[2] && seen_seq[2] <= seen_seq[1])
        begin
            $display("dependent result broadcast before its producer");
            errors++;
        end
        finish_test("dependency chain");
    endtask

    task automatic test_backpressure();
        logic [7:0] fbit;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] rd_bits;
        logic       full_seen;
        start_test();
        full_seen = 1'b0;
        for (int r = 0; r < NUM_ROB; r++)
        begin
            take_bits(1, fbit);
            take_bits(8, a);
            take_bits(8, b);
            take_bits(4, rd_bits);
            if (issue_full)
                full_seen = 1'b1;  // issue waits for it to drop
            issue_ready(fbit[0] ? FUNC_DIV : FUNC_MUL, ROB_W'(r), rd_bits[3:0], a, b);
        end
        if (!full_seen)
        begin
            $display("station never reported full under back-pressure");
            errors++;
        end
        check_all();
        finish_test("back-pressure");
    endtask

    initial
    begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 16'd7909;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = '0;
        ext_cdb      = '0;
        for (int i = 0; i < NUM_ROB; i++)
            exp_used[i] = 1'b0;
        repeat (10) @(posedge clk1);
        @(negedge clk1);
        rst = 1'b0;
        @(negedge clk1);
        test_reset();
        test_multiply();
        test_divide();
        test_ext_wakeup();
        test_chain();
        test_backpressure();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        repeat (50000) @(posedge clk1);
        $display("simulation ran past its cycle limit");
        $display("sim failed");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/tomasulo_pkg.sv
verilog/exec_pkg.sv
verilog/mul_rs.sv
verilog/mul_div_unit.sv
verilog/cdb_arbiter.sv
verilog/mul_cluster_top.sv
tb/tb_mul_cluster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mul_cluster \
    -f tb.f \
    -o tb_mul_cluster

./obj_dir/tb_mul_cluster | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
